// File: include/simon_cfg.svh
`ifndef SIMON_CFG_SVH
`define SIMON_CFG_SVH

// Word size in bits
`define SIMON_N 16

// Key words
`define SIMON_M 4

// Rounds per block and round counter width
`define SIMON_T 32
`define SIMON_CB 5

`endif

// File: design/simonPkg.sv
`default_nettype none
`include "simon_cfg.svh"

package simonPkg;

	typedef logic [`SIMON_N-1:0] simonWord;

	// Word 1 is x, word 0 is y
	typedef simonWord [1:0] simonBlock;

	// Word 0 is the first round key
	typedef simonWord [`SIMON_M-1:0] simonKey;

	typedef logic [`SIMON_CB-1:0] simonRoundIdx;

	typedef logic [7:0] simonByte;

	typedef enum logic [1:0]
	{
		INIT,
		LOAD,
		EXECUTE,
		WRITE
	} simonState;

endpackage

`default_nettype wire

// File: design/simonCtrlIf.sv
`timescale 1ns/1ps
`default_nettype none
`include "simon_cfg.svh"

interface simonCtrlIf;

	logic dataGo;
	logic keyGo;
	logic encrypt;
	logic loadPulse;
	simonPkg::simonRoundIdx round;
	logic active;
	logic writeOut;
	simonPkg::simonByte info;
	simonPkg::simonByte count;

	modport decode
	(
		output dataGo, keyGo, encrypt, loadPulse, round, active, writeOut, info, count
	);

	modport exec
	(
		input dataGo, keyGo, encrypt, loadPulse, round, active
	);

	modport result
	(
		input encrypt, writeOut, info, count
	);

endinterface

`default_nettype wire

// File: design/simonKeySchedule.sv
`timescale 1ns/1ps
`default_nettype none
`include "simon_cfg.svh"

module simonKeySchedule
(
	input logic clkALL,
	input logic nR,
	input simonPkg::simonKey KEY,
	input logic load,
	input logic step,
	input simonPkg::simonRoundIdx stepIdx,
	input simonPkg::simonRoundIdx keyIdx,
	output simonPkg::simonWord roundKey
);

	// z0 sequence, bit 0 first
	localparam logic [61:0] Z0 = 62'h19C3522FB386A45F;

	simonPkg::simonWord keyStore [`SIMON_T];
	simonPkg::simonKey window;
	simonPkg::simonWord tmp;
	simonPkg::simonWord nextWord;
	simonPkg::simonRoundIdx writeIdx;
	logic doStep;

	function automatic simonPkg::simonWord rotr(input simonPkg::simonWord w, input int s);
		return (w >> s) | (w << (`SIMON_N - s));
	endfunction

	assign doStep = step && (stepIdx < `SIMON_T - `SIMON_M);
	assign writeIdx = stepIdx + simonPkg::simonRoundIdx'(`SIMON_M);

	always_comb
	begin
		tmp = rotr(window[`SIMON_M-1], 3) ^ window[1];
		nextWord = window[0] ^ tmp ^ rotr(tmp, 1) ^ simonPkg::simonWord'(16'hfffc)
			^ simonPkg::simonWord'(Z0[stepIdx]);
	end

	always_ff @(posedge clkALL)
	begin
		if (load)
		begin
			for (int i = 0; i < `SIMON_M; i++)
				keyStore[i] <= KEY[i];
		end
		else if (doStep)
			keyStore[writeIdx] <= nextWord;
	end

	// Oldest word sits in slot 0
	always_ff @(posedge clkALL or negedge nR)
	begin
		if (!nR)
			window <= '0;
		else if (load)
			window <= KEY;
		else if (doStep)
			window <= {nextWord, window[`SIMON_M-1:1]};
	end

	assign roundKey = (doStep && keyIdx == writeIdx) ? nextWord : keyStore[keyIdx];

endmodule

`default_nettype wire

// File: design/simonRound.sv
`timescale 1ns/1ps
`default_nettype none

module simonRound
(
	input simonPkg::simonBlock in,
	input simonPkg::simonWord key,
	output simonPkg::simonBlock out
);

	simonPkg::simonWord x;
	simonPkg::simonWord y;
	simonPkg::simonWord f;

	function automatic simonPkg::simonWord rotl(input simonPkg::simonWord w, input int s);
		return (w << s) | (w >> ($bits(simonPkg::simonWord) - s));
	endfunction

	assign x = in[1];
	assign y = in[0];

	// Nonlinear mix of the upper word
	assign f = (rotl(x, 1) & rotl(x, 8)) ^ rotl(x, 2);

	assign out = {y ^ key ^ f, x};

endmodule

`default_nettype wire

// File: design/simonCmdDecode.sv
`timescale 1ns/1ps
`default_nettype none
`include "simon_cfg.svh"

module simonCmdDecode
(
	input logic clkALL,
	input logic nR,
	input logic newDATA,
	input logic newKEY,
	input logic readDATA,
	input logic doneDATA,
	input simonPkg::simonByte infoIN,
	input simonPkg::simonByte countIN,
	simonCtrlIf.decode ctrl,
	output logic loadDATA,
	output logic loadKEY,
	output logic doneKEY
);

	simonPkg::simonState state;
	logic prevData;
	logic prevKey;
	logic pendData;
	logic pendKey;
	logic riseData;
	logic riseKey;
	logic startData;
	logic accept;
	logic lastRound;
	logic holdWrite;

	assign riseData = newDATA & ~prevData;
	assign riseKey = newKEY & ~prevKey;

	// A new key only lets encryption ride along in the same pass
	assign startData = pendData & (pendKey ? infoIN[6] : doneKEY);
	assign accept = (state == simonPkg::LOAD) & ~ctrl.loadPulse & (startData | pendKey);
	assign lastRound = ctrl.round == simonPkg::simonRoundIdx'(`SIMON_T - 1);
	assign holdWrite = ctrl.dataGo & (doneDATA | readDATA);

	assign ctrl.active = state == simonPkg::EXECUTE;
	assign ctrl.writeOut = (state == simonPkg::WRITE) & ctrl.dataGo & ~holdWrite;

	// Request edges and pending flags
	always_ff @(posedge clkALL or negedge nR)
	begin
		if (!nR)
		begin
			prevData <= 1'b0;
			prevKey <= 1'b0;
			pendData <= 1'b0;
			pendKey <= 1'b0;
		end
		else
		begin
			prevData <= newDATA;
			prevKey <= newKEY;
			pendData <= riseData | (pendData & ~(accept & startData));
			pendKey <= riseKey | (pendKey & ~accept);
		end
	end

	always_ff @(posedge clkALL or negedge nR)
	begin
		if (!nR)
		begin
			state <= simonPkg::INIT;
			ctrl.loadPulse <= 1'b0;
			ctrl.dataGo <= 1'b0;
			ctrl.keyGo <= 1'b0;
			ctrl.encrypt <= 1'b0;
			ctrl.info <= '0;
			ctrl.count <= '0;
			ctrl.round <= '0;
			loadDATA <= 1'b0;
			loadKEY <= 1'b0;
			doneKEY <= 1'b0;
		end
		else
		begin
			ctrl.loadPulse <= accept;
			loadDATA <= accept & startData;
			loadKEY <= accept & pendKey;
			if (accept)
			begin
				ctrl.dataGo <= startData;
				ctrl.keyGo <= pendKey;
				ctrl.encrypt <= infoIN[6];
				ctrl.info <= infoIN;
				ctrl.count <= countIN;
			end
			unique case (state)
			simonPkg::INIT:
				state <= simonPkg::LOAD;
			simonPkg::LOAD:
			begin
				if (ctrl.loadPulse)
				begin
					state <= simonPkg::EXECUTE;
					ctrl.round <= '0;
				end
			end
			simonPkg::EXECUTE:
			begin
				ctrl.round <= ctrl.round + simonPkg::simonRoundIdx'(1);
				if (lastRound)
					state <= simonPkg::WRITE;
			end
			simonPkg::WRITE:
			begin
				// Result held here until the host has read the previous one
				if (!holdWrite)
				begin
					state <= simonPkg::LOAD;
					if (ctrl.keyGo)
						doneKEY <= 1'b1;
				end
			end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/simonCipherCore.sv
`timescale 1ns/1ps
`default_nettype none
`include "simon_cfg.svh"

module simonCipherCore
(
	input logic clkALL,
	input logic nR,
	input simonPkg::simonBlock inDATA,
	input simonPkg::simonKey KEY,
	simonCtrlIf.exec ctrl,
	output simonPkg::simonBlock block
);

	simonPkg::simonBlock roundOut;
	simonPkg::simonWord roundKey;
	simonPkg::simonRoundIdx keyIdx;
	logic keyLoad;
	logic keyStep;

	assign keyLoad = ctrl.loadPulse & ctrl.keyGo;
	assign keyStep = ctrl.active & ctrl.keyGo;

	// Decryption walks the round keys backwards
	assign keyIdx = ctrl.encrypt ? ctrl.round
		: simonPkg::simonRoundIdx'(`SIMON_T - 1) - ctrl.round;

	simonKeySchedule keySched
	(
		.clkALL(clkALL),
		.nR(nR),
		.KEY(KEY),
		.load(keyLoad),
		.step(keyStep),
		.stepIdx(ctrl.round),
		.keyIdx(keyIdx),
		.roundKey(roundKey)
	);

	simonRound rnd
	(
		.in(block),
		.key(roundKey),
		.out(roundOut)
	);

	always_ff @(posedge clkALL or negedge nR)
	begin
		if (!nR)
			block <= '0;
		else if (ctrl.loadPulse && ctrl.dataGo)
		begin
			// Swapped words let decryption reuse the forward round
			if (ctrl.encrypt)
				block <= inDATA;
			else
				block <= {inDATA[0], inDATA[1]};
		end
		else if (ctrl.active && ctrl.dataGo)
			block <= roundOut;
	end

endmodule

`default_nettype wire

// File: design/simonResult.sv
`timescale 1ns/1ps
`default_nettype none
`include "simon_cfg.svh"

module simonResult
(
	input logic clkALL,
	input logic nR,
	input simonPkg::simonBlock block,
	input logic readDATA,
	simonCtrlIf.result ctrl,
	output simonPkg::simonBlock outDATA,
	output simonPkg::simonByte infoOUT,
	output simonPkg::simonByte countOUT,
	output logic doneDATA
);

	simonPkg::simonBlock finalBlock;

	// Undo the decryption word swap
	assign finalBlock = ctrl.encrypt ? block : {block[0], block[1]};

	always_ff @(posedge clkALL or negedge nR)
	begin
		if (!nR)
		begin
			outDATA <= '0;
			infoOUT <= '0;
			countOUT <= '0;
		end
		else if (ctrl.writeOut)
		begin
			outDATA <= finalBlock;
			infoOUT <= {ctrl.info[7:5], ~ctrl.info[4], ctrl.info[3:0]};
			countOUT <= ctrl.count;
		end
	end

	// Host acknowledges with readDATA
	always_ff @(posedge clkALL or negedge nR)
	begin
		if (!nR)
			doneDATA <= 1'b0;
		else if (ctrl.writeOut)
			doneDATA <= 1'b1;
		else if (readDATA)
			doneDATA <= 1'b0;
	end

endmodule

`default_nettype wire

// File: design/simonTop.sv
`timescale 1ns/1ps
`default_nettype none
`include "simon_cfg.svh"

module simonTop
(
	input logic clkALL,
	input logic nR,
	input logic newDATA,
	input logic newKEY,
	input logic readDATA,
	input simonPkg::simonByte infoIN,
	input simonPkg::simonByte countIN,
	input simonPkg::simonBlock inDATA,
	input simonPkg::simonKey KEY,
	output logic loadDATA,
	output logic loadKEY,
	output logic doneDATA,
	output logic doneKEY,
	output simonPkg::simonByte infoOUT,
	output simonPkg::simonByte countOUT,
	output simonPkg::simonBlock outDATA
);

	simonPkg::simonBlock block;

	simonCtrlIf ctrlBus();

	simonCmdDecode decode
	(
		.clkALL(clkALL),
		.nR(nR),
		.newDATA(newDATA),
		.newKEY(newKEY),
		.readDATA(readDATA),
		.doneDATA(doneDATA),
		.infoIN(infoIN),
		.countIN(countIN),
		.ctrl(ctrlBus),
		.loadDATA(loadDATA),
		.loadKEY(loadKEY),
		.doneKEY(doneKEY)
	);

	simonCipherCore core
	(
		.clkALL(clkALL),
		.nR(nR),
		.inDATA(inDATA),
		.KEY(KEY),
		.ctrl(ctrlBus),
		.block(block)
	);

	simonResult result
	(
		.clkALL(clkALL),
		.nR(nR),
		.block(block),
		.readDATA(readDATA),
		.ctrl(ctrlBus),
		.outDATA(outDATA),
		.infoOUT(infoOUT),
		.countOUT(countOUT),
		.doneDATA(doneDATA)
	);

endmodule

`default_nettype wire

// File: sim/simonTb.sv
`timescale 1ns/1ps
`default_nettype none

module simonTb;

	localparam int timeoutCycles = 200;
	localparam int sigDone = 0;
	localparam int sigNotDone = 1;
	localparam int sigLoadData = 2;
	localparam int sigLoadKey = 3;

	// z0 sequence, first bit at index 0
	localparam logic [0:61] z0Seq =
		62'b1111101000100101011000011100110_1111101000100101011000011100110;

	logic clkALL, nR, newDATA, newKEY, readDATA;
	logic [7:0] infoIN, countIN, infoOUT, countOUT;
	logic [31:0] inDATA, outDATA;
	logic [63:0] KEY;
	logic loadDATA, loadKEY, doneDATA, doneKEY;

	logic [15:0] refKeys [32];
	logic [31:0] plain [20];
	logic [31:0] cipher [20];
	logic [31:0] expA, expB, ptA, ptB;
	logic [7:0] info, count, infoA, countA, infoB, countB;
	logic [63:0] key;
	int unsigned seedDummy;
	int cycles;

	simonTop uut
	(
		.clkALL(clkALL), .nR(nR), .newDATA(newDATA), .newKEY(newKEY), .readDATA(readDATA),
		.infoIN(infoIN), .countIN(countIN), .inDATA(inDATA), .KEY(KEY),
		.loadDATA(loadDATA), .loadKEY(loadKEY), .doneDATA(doneDATA), .doneKEY(doneKEY),
		.infoOUT(infoOUT), .countOUT(countOUT), .outDATA(outDATA)
	);

	initial
	begin
		clkALL = 1'b0;
		forever
			#50 clkALL = ~clkALL;
	end

	function automatic logic [15:0] rotl16(input logic [15:0] w, input int s);
		return (w << s) | (w >> (16 - s));
	endfunction

	function automatic logic [15:0] rotr16(input logic [15:0] w, input int s);
		return (w >> s) | (w << (16 - s));
	endfunction

	function automatic logic [15:0] feistel(input logic [15:0] w);
		return (rotl16(w, 1) & rotl16(w, 8)) ^ rotl16(w, 2);
	endfunction

	function automatic void expandKey(input logic [63:0] k);
		logic [15:0] tmp;
		for (int i = 0; i < 4; i++)
			refKeys[i] = k[16*i +: 16];
		for (int i = 4; i < 32; i++)
		begin
			tmp = rotr16(refKeys[i-1], 3) ^ refKeys[i-3];
			tmp = tmp ^ rotr16(tmp, 1);
			// Constant 0xfffc folded in as inversion and 3
			refKeys[i] = ~refKeys[i-4] ^ tmp ^ 16'(z0Seq[i-4]) ^ 16'h0003;
		end
	endfunction

	function automatic logic [31:0] encryptRef(input logic [31:0] pt);
		logic [15:0] x, y, t;
		x = pt[31:16];
		y = pt[15:0];
		for (int i = 0; i < 32; i++)
		begin
			t = x;
			x = y ^ feistel(x) ^ refKeys[i];
			y = t;
		end
		return {x, y};
	endfunction

	function automatic logic [31:0] decryptRef(input logic [31:0] ct);
		logic [15:0] x, y, t;
		x = ct[31:16];
		y = ct[15:0];
		for (int i = 31; i >= 0; i--)
		begin
			t = y;
			y = x ^ feistel(y) ^ refKeys[i];
			x = t;
		end
		return {x, y};
	endfunction

	task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	// Counts falling edges until the chosen condition holds
	task automatic waitFor(input int which, input string what, output int n);
		bit seen;
		n = 0;
		seen = 0;
		while (!seen && n < timeoutCycles)
		begin
			@(negedge clkALL);
			n++;
			case (which)
				sigDone: seen = doneDATA;
				sigNotDone: seen = !doneDATA;
				sigLoadData: seen = loadDATA;
				default: seen = loadKEY;
			endcase
		end
		if (!seen)
		begin
			$display("Timeout while waiting for %s", what);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	task automatic issue(input logic [31:0] data, input logic [63:0] k, input logic [7:0] inf,
		input logic [7:0] cnt, input bit withData, input bit withKey);
		@(posedge clkALL);
		inDATA <= data;
		KEY <= k;
		infoIN <= inf;
		countIN <= cnt;
		newDATA <= withData;
		newKEY <= withKey;
		@(posedge clkALL);
		newDATA <= 1'b0;
		newKEY <= 1'b0;
	endtask

	task automatic checkResult(input logic [31:0] exp, input logic [7:0] inf,
		input logic [7:0] cnt);
		checkValue("outDATA", outDATA, exp);
		checkValue("infoOUT", infoOUT, inf ^ 8'h10);
		checkValue("countOUT", countOUT, cnt);
	endtask

	task automatic readResult();
		int n;
		@(posedge clkALL);
		readDATA <= 1'b1;
		@(posedge clkALL);
		readDATA <= 1'b0;
		waitFor(sigNotDone, "doneDATA to clear", n);
	endtask

	initial
	begin
		nR = 1'b0;
		newDATA = 1'b0;
		newKEY = 1'b0;
		readDATA = 1'b0;
		infoIN = '0;
		countIN = '0;
		inDATA = '0;
		KEY = '0;
		seedDummy = $urandom(32'h531e66a0);
		repeat (8)
			@(posedge clkALL);
		nR <= 1'b1;
		@(negedge clkALL);
		checkValue("loadDATA", loadDATA, 0);
		checkValue("loadKEY", loadKEY, 0);
		checkValue("doneDATA", doneDATA, 0);
		checkValue("doneKEY", doneKEY, 0);
		checkValue("outDATA", outDATA, 0);
		checkValue("infoOUT", infoOUT, 0);
		checkValue("countOUT", countOUT, 0);

		// Published 32/64 vector
		key = {16'h1918, 16'h1110, 16'h0908, 16'h0100};
		expandKey(key);
		checkValue("reference cipher", encryptRef(32'h65656877), 32'hc69be9bb);
		issue(32'h65656877, key, 8'h40, 8'h01, 1, 1);
		waitFor(sigLoadData, "loadDATA", cycles);
		checkValue("loadKEY", loadKEY, 1);
		waitFor(sigDone, "doneDATA", cycles);
		checkValue("doneDATA latency", cycles, 34);
		checkResult(32'hc69be9bb, 8'h40, 8'h01);
		checkValue("doneKEY", doneKEY, 1);
		readResult();

		for (int i = 0; i < 20; i++)
		begin
			plain[i] = $urandom();
			cipher[i] = encryptRef(plain[i]);
			info = 8'($urandom()) | 8'h40;
			count = 8'($urandom());
			issue(plain[i], key, info, count, 1, 0);
			waitFor(sigDone, "doneDATA", cycles);
			checkResult(cipher[i], info, count);
			readResult();
		end

		for (int i = 0; i < 20; i++)
		begin
			info = 8'($urandom()) & 8'hbf;
			count = 8'($urandom());
			issue(cipher[i], key, info, count, 1, 0);
			waitFor(sigDone, "doneDATA", cycles);
			checkResult(plain[i], info, count);
			readResult();
		end

		// Decrypt together with a fresh key
		key = {$urandom(), $urandom()};
		expandKey(key);
		ptA = $urandom();
		expA = encryptRef(ptA);
		info = 8'($urandom()) & 8'hbf;
		count = 8'($urandom());
		issue(expA, key, info, count, 1, 1);
		waitFor(sigLoadKey, "loadKEY", cycles);
		checkValue("loadDATA", loadDATA, 0);
		waitFor(sigLoadData, "loadDATA", cycles);
		waitFor(sigDone, "doneDATA", cycles);
		checkResult(decryptRef(expA), info, count);
		checkValue("decrypted block", outDATA, ptA);
		readResult();

		// Second result must wait for the host read
		ptA = $urandom();
		ptB = $urandom();
		expA = encryptRef(ptA);
		expB = encryptRef(ptB);
		infoA = 8'($urandom()) | 8'h40;
		infoB = 8'($urandom()) | 8'h40;
		countA = 8'($urandom());
		countB = 8'($urandom());
		issue(ptA, key, infoA, countA, 1, 0);
		waitFor(sigDone, "doneDATA", cycles);
		checkResult(expA, infoA, countA);
		issue(ptB, key, infoB, countB, 1, 0);
		waitFor(sigLoadData, "loadDATA", cycles);
		repeat (40)
		begin
			@(negedge clkALL);
			checkResult(expA, infoA, countA);
			checkValue("doneDATA", doneDATA, 1);
		end
		readResult();
		waitFor(sigDone, "doneDATA", cycles);
		checkResult(expB, infoB, countB);
		readResult();

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+include
design/simonPkg.sv
design/simonCtrlIf.sv
design/simonKeySchedule.sv
design/simonRound.sv
design/simonCmdDecode.sv
design/simonCipherCore.sv
design/simonResult.sv
design/simonTop.sv
sim/simonTb.sv
